// ==== hw/lc3b_pkg.sv ====
package lc3b_pkg;

typedef logic [15:0] lc3b_word;     // data and address word
typedef logic [2:0]  lc3b_reg;      // register index
typedef logic [2:0]  lc3b_nzp;      // n, z, p flags

// only the opcodes the core executes, others retire as no-ops
typedef enum logic [3:0] {
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_and = 4'b0101,
    op_not = 4'b1001,
    op_lea = 4'b1110
} lc3b_opcode;

localparam lc3b_nzp cc_n = 3'b100;
localparam lc3b_nzp cc_z = 3'b010;
localparam lc3b_nzp cc_p = 3'b001;

typedef struct packed {
    lc3b_opcode opcode;
    lc3b_reg    dest;
    lc3b_reg    sr1;
    logic       imm;            // 0 here
    logic [1:0] unused;
    lc3b_reg    sr2;
} lc3b_instr_reg;

typedef struct packed {
    lc3b_opcode opcode;
    lc3b_reg    dest;
    lc3b_reg    sr1;
    logic       imm;            // 1 here
    logic [4:0] imm5;
} lc3b_instr_imm;

typedef struct packed {
    lc3b_opcode opcode;
    logic       n;
    logic       z;
    logic       p;
    logic [8:0] offset9;        // also the LEA offset
} lc3b_instr_br;

typedef union packed {
    lc3b_instr_reg r;
    lc3b_instr_imm i;
    lc3b_instr_br  b;
} lc3b_instr;

endpackage : lc3b_pkg

// ==== hw/lc3b_fetch.sv ====
`timescale 1ns/1ns

module lc3b_fetch #(
    parameter int QUEUE_DEPTH = 4,
    parameter lc3b_pkg::lc3b_word RESET_PC = 16'h0000
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic instr_resp,
    input  lc3b_pkg::lc3b_word instr_rdata,
    input  logic pop,
    input  logic redirect,
    input  lc3b_pkg::lc3b_word redirect_pc,
    output logic instr_read,
    output lc3b_pkg::lc3b_word instr_address,
    output logic push,
    output lc3b_pkg::lc3b_word push_word,
    output lc3b_pkg::lc3b_word push_pc
);

localparam int CREDIT_W = $clog2(QUEUE_DEPTH + 1);

lc3b_pkg::lc3b_word pc;
logic outstanding;          // one read in flight
logic epoch;
logic req_epoch;            // epoch of the read in flight
logic [CREDIT_W-1:0] credits;
logic [CREDIT_W-1:0] credits_next;
logic issue;
logic resp_ok;
logic resp_drop;

assign issue = !outstanding && !redirect && (credits < CREDIT_W'(QUEUE_DEPTH));
assign resp_ok = instr_resp && (req_epoch == epoch) && !redirect;
assign resp_drop = instr_resp && !resp_ok;

// credits track queue entries plus the read in flight
always_comb
begin
    credits_next = credits;
    if (redirect)
        credits_next = CREDIT_W'(outstanding && !instr_resp);  // queue is flushed
    else
    begin
        if (issue)
            credits_next = credits_next + 1'b1;
        if (pop)
            credits_next = credits_next - 1'b1;
        if (resp_drop)
            credits_next = credits_next - 1'b1;  // stale word never enters queue
    end
end

always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        pc <= RESET_PC;
        outstanding <= 1'b0;
        epoch <= 1'b0;
        req_epoch <= 1'b0;
        credits <= '0;
        instr_read <= 1'b0;
        push <= 1'b0;
    end
    else
    begin
        instr_read <= issue;
        push <= resp_ok;
        credits <= credits_next;
        if (redirect)
        begin
            pc <= redirect_pc;
            epoch <= ~epoch;            // old path responses now mismatch
        end
        else if (issue)
            pc <= pc + 16'd2;
        if (issue)
        begin
            outstanding <= 1'b1;
            req_epoch <= epoch;
        end
        else if (instr_resp)
            outstanding <= 1'b0;
    end
end

always_ff @(posedge clk)
begin
    if (issue)
        instr_address <= pc;
    if (resp_ok)
    begin
        push_word <= instr_rdata;
        push_pc <= instr_address;       // address still held from issue
    end
end

resp_has_read: assert property (@(posedge clk) disable iff (!rst_n)
    instr_resp |-> outstanding)
    else $error("instr_resp without an outstanding read");

endmodule : lc3b_fetch

// ==== hw/lc3b_instr_queue.sv ====
`timescale 1ns/1ns

module lc3b_instr_queue #(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  lc3b_pkg::lc3b_word push_word,
    input  lc3b_pkg::lc3b_word push_pc,
    input  logic pop,
    input  logic flush,
    output logic empty,
    output lc3b_pkg::lc3b_word head_word,
    output lc3b_pkg::lc3b_word head_pc
);

localparam int PTR_W = $clog2(QUEUE_DEPTH);
localparam int COUNT_W = PTR_W + 1;

lc3b_pkg::lc3b_word word_mem [QUEUE_DEPTH];
lc3b_pkg::lc3b_word pc_mem [QUEUE_DEPTH];
logic [PTR_W-1:0] rd_ptr;
logic [PTR_W-1:0] wr_ptr;
logic [COUNT_W-1:0] count;
logic full;

assign empty = (count == '0);
assign full = (count == COUNT_W'(QUEUE_DEPTH));
assign head_word = word_mem[rd_ptr];
assign head_pc = pc_mem[rd_ptr];

always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count <= '0;
    end
    else if (flush)
    begin
        rd_ptr <= '0;               // flush wins over push and pop
        wr_ptr <= '0;
        count <= '0;
    end
    else
    begin
        if (push)
            wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
        if (pop)
            rd_ptr <= rd_ptr + 1'b1;
        case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk)
begin
    if (push)
    begin
        word_mem[wr_ptr] <= push_word;
        pc_mem[wr_ptr] <= push_pc;
    end
end

// fetch credits must keep the queue from overflowing
no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("push into a full queue");

no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("pop from an empty queue");

endmodule : lc3b_instr_queue

// ==== hw/lc3b_regfile.sv ====
`timescale 1ns/1ns

module lc3b_regfile
(
    input  logic clk,
    input  logic rst_n,
    input  lc3b_pkg::lc3b_reg src_a,
    input  lc3b_pkg::lc3b_reg src_b,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b,
    input  logic write,
    input  lc3b_pkg::lc3b_reg dest,
    input  lc3b_pkg::lc3b_word wdata
);

lc3b_pkg::lc3b_word regs [8];

// R0..R7 start at zero
always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        for (int i = 0; i < 8; i++)
        begin
            regs[i] <= '0;
        end
    end
    else if (write)
    begin
        regs[dest] <= wdata;
    end
end

// no bypass, a write is seen from the next cycle on
assign reg_a = regs[src_a];
assign reg_b = regs[src_b];

endmodule : lc3b_regfile

// ==== hw/lc3b_execute.sv ====
`timescale 1ns/1ns

module lc3b_execute
(
    input  logic clk,
    input  logic rst_n,
    input  logic empty,
    input  lc3b_pkg::lc3b_word head_word,
    input  lc3b_pkg::lc3b_word head_pc,
    output logic pop,
    output logic redirect,
    output lc3b_pkg::lc3b_word redirect_pc,
    output logic retire,
    output lc3b_pkg::lc3b_word retire_pc,
    output logic wb_write,
    output lc3b_pkg::lc3b_reg wb_reg,
    output lc3b_pkg::lc3b_word wb_data,
    output lc3b_pkg::lc3b_nzp cc
);

lc3b_pkg::lc3b_instr instr;
lc3b_pkg::lc3b_opcode opcode;
lc3b_pkg::lc3b_word sr1_val;
lc3b_pkg::lc3b_word sr2_val;
lc3b_pkg::lc3b_word imm5_sext;
lc3b_pkg::lc3b_word operand_b;
lc3b_pkg::lc3b_word pc_plus2;
lc3b_pkg::lc3b_word offset9_adj;
lc3b_pkg::lc3b_word target;
lc3b_pkg::lc3b_word result;
lc3b_pkg::lc3b_nzp new_cc;
lc3b_pkg::lc3b_nzp br_nzp;
logic dec_write;
logic dec_set_cc;
logic dec_taken;

assign instr = head_word;
assign opcode = instr.r.opcode;

// the head after a taken branch is wrong path, leave it for the flush
assign pop = !empty && !redirect;

// regfile is written on the pop edge so the next instruction sees it
lc3b_regfile regfile_i
(
    .clk(clk),
    .rst_n(rst_n),
    .src_a(instr.r.sr1),
    .src_b(instr.r.sr2),
    .reg_a(sr1_val),
    .reg_b(sr2_val),
    .write(pop && dec_write),
    .dest(instr.r.dest),
    .wdata(result)
);

assign imm5_sext = {{11{instr.i.imm5[4]}}, instr.i.imm5};
assign operand_b = instr.r.imm ? imm5_sext : sr2_val;
assign br_nzp = {instr.b.n, instr.b.z, instr.b.p};

// shared by BR target and LEA
assign offset9_adj = {{6{instr.b.offset9[8]}}, instr.b.offset9, 1'b0};
assign pc_plus2 = head_pc + 16'd2;
assign target = pc_plus2 + offset9_adj;

always_comb
begin
    result = '0;
    dec_write = 1'b0;
    dec_set_cc = 1'b0;
    dec_taken = 1'b0;
    case (opcode)
        lc3b_pkg::op_add:
        begin
            result = sr1_val + operand_b;
            dec_write = 1'b1;
            dec_set_cc = 1'b1;
        end
        lc3b_pkg::op_and:
        begin
            result = sr1_val & operand_b;
            dec_write = 1'b1;
            dec_set_cc = 1'b1;
        end
        lc3b_pkg::op_not:
        begin
            result = ~sr1_val;
            dec_write = 1'b1;
            dec_set_cc = 1'b1;
        end
        lc3b_pkg::op_lea:
        begin
            result = target;        // cc untouched
            dec_write = 1'b1;
        end
        lc3b_pkg::op_br:
            dec_taken = |(br_nzp & cc);
        default:
            dec_write = 1'b0;       // unsupported, retires as no-op
    endcase
end

always_comb
begin
    if (result[15])
        new_cc = lc3b_pkg::cc_n;
    else if (result == '0)
        new_cc = lc3b_pkg::cc_z;
    else
        new_cc = lc3b_pkg::cc_p;
end

always_ff @(posedge clk)
begin
    if (!rst_n)
    begin
        retire <= 1'b0;
        wb_write <= 1'b0;
        redirect <= 1'b0;
        cc <= lc3b_pkg::cc_z;
    end
    else
    begin
        retire <= pop;
        wb_write <= pop && dec_write;
        redirect <= pop && dec_taken;   // lines up with the branch retire
        if (pop && dec_set_cc)
            cc <= new_cc;
    end
end

always_ff @(posedge clk)
begin
    if (pop)
    begin
        retire_pc <= head_pc;
        wb_reg <= instr.r.dest;
        wb_data <= result;
        redirect_pc <= target;
    end
end

cc_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(cc))
    else $error("cc does not hold exactly one flag");

endmodule : lc3b_execute

// ==== hw/lc3b_core.sv ====
`timescale 1ns/1ns

module lc3b_core #(
    parameter int QUEUE_DEPTH = 4,
    parameter lc3b_pkg::lc3b_word RESET_PC = 16'h0000
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic instr_resp,
    input  lc3b_pkg::lc3b_word instr_rdata,
    output logic instr_read,
    output lc3b_pkg::lc3b_word instr_address,
    output logic retire,
    output lc3b_pkg::lc3b_word retire_pc,
    output logic wb_write,
    output lc3b_pkg::lc3b_reg wb_reg,
    output lc3b_pkg::lc3b_word wb_data,
    output lc3b_pkg::lc3b_nzp cc
);

logic push;
lc3b_pkg::lc3b_word push_word;
lc3b_pkg::lc3b_word push_pc;
logic pop;
logic empty;
lc3b_pkg::lc3b_word head_word;
lc3b_pkg::lc3b_word head_pc;
logic redirect;                     // also flushes the queue
lc3b_pkg::lc3b_word redirect_pc;

lc3b_fetch #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .RESET_PC(RESET_PC)
) fetch_i (
    .clk(clk),
    .rst_n(rst_n),
    .instr_resp(instr_resp),
    .instr_rdata(instr_rdata),
    .pop(pop),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .instr_read(instr_read),
    .instr_address(instr_address),
    .push(push),
    .push_word(push_word),
    .push_pc(push_pc)
);

lc3b_instr_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
) queue_i (
    .clk(clk),
    .rst_n(rst_n),
    .push(push),
    .push_word(push_word),
    .push_pc(push_pc),
    .pop(pop),
    .flush(redirect),
    .empty(empty),
    .head_word(head_word),
    .head_pc(head_pc)
);

lc3b_execute execute_i
(
    .clk(clk),
    .rst_n(rst_n),
    .empty(empty),
    .head_word(head_word),
    .head_pc(head_pc),
    .pop(pop),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .retire(retire),
    .retire_pc(retire_pc),
    .wb_write(wb_write),
    .wb_reg(wb_reg),
    .wb_data(wb_data),
    .cc(cc)
);

endmodule : lc3b_core

// ==== include/lc3b_tb_program.svh ====
`ifndef LC3B_TB_PROGRAM_SVH
`define LC3B_TB_PROGRAM_SVH

// 15 instructions up to the self loop, then four laps of it
localparam int expected_retires = 19;

function automatic lc3b_pkg::lc3b_word program_word(input lc3b_pkg::lc3b_word addr);
    case (addr)
        16'h0000: return 16'h1225;      // ADD R1, R0, #5
        16'h0002: return 16'h147d;      // ADD R2, R1, #-3
        16'h0004: return 16'h1642;      // ADD R3, R1, R2
        16'h0006: return 16'h58e6;      // AND R4, R3, #6
        16'h0008: return 16'h5b02;      // AND R5, R4, R2
        16'h000a: return 16'h9d7f;      // NOT R6, R5
        16'h000c: return 16'h1da3;      // ADD R6, R6, #3 gives zero
        16'h000e: return 16'hee04;      // LEA R7, #4
        16'h0010: return 16'h0402;      // BRz #2, taken
        16'h0012: return 16'h1261;      // wrong path
        16'h0014: return 16'h1261;      // wrong path
        16'h0016: return 16'h11b0;      // ADD R0, R6, #-16
        16'h0018: return 16'h0203;      // BRp #3, falls through
        16'h001a: return 16'h5403;      // AND R2, R0, R3
        16'h001c: return 16'h0805;      // BRn #5, falls through
        16'h001e: return 16'hd000;      // reserved opcode, no-op
        16'h0020: return 16'h16c3;      // ADD R3, R3, R3
        16'h0022: return 16'h0fff;      // BRnzp #-1, loops on itself
        default: return {4'b1101, addr[11:0] ^ {8'h00, addr[15:12]}};
    endcase
endfunction

function automatic lc3b_pkg::lc3b_word sign_extend(input logic [8:0] field, input int width);
    lc3b_pkg::lc3b_word low_mask;
    low_mask = ~(16'hffff << width);
    if (field[width-1])
        return 16'(field) | ~low_mask;
    return 16'(field) & low_mask;
endfunction

function automatic lc3b_pkg::lc3b_nzp flags_for(input lc3b_pkg::lc3b_word value);
    if (value[15])
        return lc3b_pkg::cc_n;
    if (value == 16'h0000)
        return lc3b_pkg::cc_z;
    return lc3b_pkg::cc_p;
endfunction

// runs one instruction of the reference machine and sets exp_* for its retire
task automatic advance_model();
    lc3b_pkg::lc3b_word word;
    lc3b_pkg::lc3b_word src1;
    lc3b_pkg::lc3b_word src2;
    lc3b_pkg::lc3b_word next_pc;
    word = program_word(model_pc);
    src1 = model_regs[word[8:6]];
    src2 = word[5] ? sign_extend(word[8:0], 5) : model_regs[word[2:0]];
    next_pc = model_pc + 16'd2;
    exp_pc = model_pc;
    exp_write = 1'b1;
    exp_reg = word[11:9];
    exp_data = 16'h0000;
    case (word[15:12])
        lc3b_pkg::op_add: exp_data = src1 + src2;
        lc3b_pkg::op_and: exp_data = src1 & src2;
        lc3b_pkg::op_not: exp_data = ~src1;
        lc3b_pkg::op_lea: exp_data = next_pc + (sign_extend(word[8:0], 9) << 1);
        default: exp_write = 1'b0;
    endcase
    if (word[15:12] inside {lc3b_pkg::op_add, lc3b_pkg::op_and, lc3b_pkg::op_not})
        model_cc = flags_for(exp_data);
    if (word[15:12] == lc3b_pkg::op_br && (word[11:9] & model_cc) != 3'b000)
        next_pc = next_pc + (sign_extend(word[8:0], 9) << 1);   // taken
    if (exp_write)
        model_regs[exp_reg] = exp_data;
    exp_cc = model_cc;
    model_pc = next_pc;
endtask

`endif

// ==== verification/lc3b_core_tb.sv ====
`timescale 1ns/1ns

module lc3b_core_tb;

localparam int timeout_cycles = 2000;
localparam lc3b_pkg::lc3b_word reset_pc = 16'h0000;

logic clk = 1'b0;
logic rst_n;
logic instr_resp;
lc3b_pkg::lc3b_word instr_rdata;
logic instr_read;
lc3b_pkg::lc3b_word instr_address;
logic retire;
lc3b_pkg::lc3b_word retire_pc;
logic wb_write;
lc3b_pkg::lc3b_reg wb_reg;
lc3b_pkg::lc3b_word wb_data;
lc3b_pkg::lc3b_nzp cc;

// reference machine and its prediction for the current retire
lc3b_pkg::lc3b_word model_regs [8];
lc3b_pkg::lc3b_word model_pc;
lc3b_pkg::lc3b_nzp model_cc;
lc3b_pkg::lc3b_word exp_pc;
logic exp_write;
lc3b_pkg::lc3b_reg exp_reg;
lc3b_pkg::lc3b_word exp_data;
lc3b_pkg::lc3b_nzp exp_cc;
int retire_count;
int value_errors;
int other_errors;

`include "lc3b_tb_program.svh"

lc3b_core #(
    .QUEUE_DEPTH(4),
    .RESET_PC(reset_pc)
) dut_i (
    .clk(clk),
    .rst_n(rst_n),
    .instr_resp(instr_resp),
    .instr_rdata(instr_rdata),
    .instr_read(instr_read),
    .instr_address(instr_address),
    .retire(retire),
    .retire_pc(retire_pc),
    .wb_write(wb_write),
    .wb_reg(wb_reg),
    .wb_data(wb_data),
    .cc(cc)
);

always #4 clk = ~clk;

task automatic report_mismatch(input string name, input logic [15:0] got,
    input logic [15:0] expected);
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    value_errors++;
endtask

after_reset_read: assert property (@(posedge clk) !rst_n |=> !instr_read)
    else report_mismatch("instr_read", 16'(1), 16'(0));
after_reset_retire: assert property (@(posedge clk) !rst_n |=> !retire)
    else report_mismatch("retire", 16'(1), 16'(0));
after_reset_write: assert property (@(posedge clk) !rst_n |=> !wb_write)
    else report_mismatch("wb_write", 16'(1), 16'(0));
after_reset_cc: assert property (@(posedge clk) !rst_n |=> cc == lc3b_pkg::cc_z)
    else report_mismatch("cc", 16'($sampled(cc)), 16'(lc3b_pkg::cc_z));

retire_pc_ok: assert property (@(posedge clk) disable iff (!rst_n)
    retire |-> retire_pc == exp_pc)
    else report_mismatch("retire_pc", $sampled(retire_pc), $sampled(exp_pc));
wb_write_ok: assert property (@(posedge clk) disable iff (!rst_n)
    retire |-> wb_write == exp_write)
    else report_mismatch("wb_write", 16'($sampled(wb_write)), 16'($sampled(exp_write)));
write_with_retire: assert property (@(posedge clk) disable iff (!rst_n)
    wb_write |-> retire)
    else report_mismatch("retire", 16'(0), 16'(1));
wb_reg_ok: assert property (@(posedge clk) disable iff (!rst_n)
    retire && exp_write |-> wb_reg == exp_reg)
    else report_mismatch("wb_reg", 16'($sampled(wb_reg)), 16'($sampled(exp_reg)));
wb_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
    retire && exp_write |-> wb_data == exp_data)
    else report_mismatch("wb_data", $sampled(wb_data), $sampled(exp_data));
cc_ok: assert property (@(posedge clk) disable iff (!rst_n)
    retire |-> cc == exp_cc)
    else report_mismatch("cc", 16'($sampled(cc)), 16'($sampled(exp_cc)));

// instruction memory with one read at a time and 1 to 4 cycles of latency
initial
begin
    int wait_cycles;
    logic busy;
    lc3b_pkg::lc3b_word read_addr;
    void'($urandom(30));            // latency draws come from this process
    instr_resp = 1'b0;
    instr_rdata = '0;
    busy = 1'b0;
    wait_cycles = 0;
    read_addr = '0;
    forever
    begin
        @(posedge clk);
        #1;
        instr_resp = 1'b0;
        if (busy && instr_read)
        begin
            $display("memory model: a second read came at %0t ns before the first answer",
                $time);
            other_errors++;
        end
        if (busy)
        begin
            wait_cycles--;
            if (wait_cycles == 0)
            begin
                instr_resp = 1'b1;
                instr_rdata = program_word(read_addr);
                busy = 1'b0;
            end
        end
        else if (instr_read)
        begin
            busy = 1'b1;
            wait_cycles = int'($urandom_range(4, 1));
            read_addr = instr_address;
        end
    end
end

// step the reference machine once per retire just after the edge
always @(posedge clk)
begin
    #1;
    if (retire)
    begin
        advance_model();
        retire_count++;
    end
end

initial
begin
    int cycles;
    rst_n = 1'b0;
    model_pc = reset_pc;
    model_cc = lc3b_pkg::cc_z;
    for (int i = 0; i < 8; i++)
    begin
        model_regs[i] = '0;
    end
    exp_pc = reset_pc;
    exp_write = 1'b0;
    exp_reg = '0;
    exp_data = '0;
    exp_cc = lc3b_pkg::cc_z;
    retire_count = 0;
    value_errors = 0;
    other_errors = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    cycles = 0;
    while (retire_count < expected_retires && cycles < timeout_cycles)
    begin
        @(posedge clk);
        cycles++;
    end
    if (retire_count < expected_retires)
    begin
        $display("timeout: only %0d of %0d instructions retired in %0d cycles",
            retire_count, expected_retires, timeout_cycles);
        other_errors++;
    end
    repeat (2) @(posedge clk);  // last retire checks fire
    $display("errors: %0d wrong values, %0d other failures, %0d instructions retired",
        value_errors, other_errors, retire_count);
    if (value_errors == 0 && other_errors == 0)
        $display("Simulation passed");
    else
        $display("Simulation failed");
    $finish;
end

endmodule : lc3b_core_tb

// ==== lc3b_core.f ====
+incdir+include
hw/lc3b_pkg.sv
hw/lc3b_fetch.sv
hw/lc3b_instr_queue.sv
hw/lc3b_regfile.sv
hw/lc3b_execute.sv
hw/lc3b_core.sv
verification/lc3b_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the lc3b_core testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file="$build_dir/sim.log"
sim_bin="$build_dir/obj_dir/lc3b_core_sim"

if ! command -v verilator > /dev/null 2>&1; then
    echo "run_sim: verilator is not on the PATH"
    exit 1
fi

if ! mkdir -p "$build_dir"; then
    echo "run_sim: cannot create $build_dir"
    exit 1
fi

if ! verilator --binary --timing --assert -sv -Wno-fatal \
    --top-module lc3b_core_tb -Mdir "$build_dir/obj_dir" -o lc3b_core_sim \
    -f lc3b_core.f; then
    echo "run_sim: the Verilator build failed"
    exit 1
fi

"$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
    echo "run_sim: the simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Simulation passed" "$log_file"; then
    exit 0
fi
echo "run_sim: no pass line found in $log_file"
exit 1
